// ==== llc_reg_pkg.sv ====
package llc_reg_pkg;

  // Register bus widths
  typedef logic [11:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Bus request, held by the master until ready is seen
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // Bus response, ready is a single-cycle pulse
  typedef struct packed {
    logic      ready;
    logic      error;
    reg_data_t rdata;
  } reg_rsp_t;

  // Region split between configuration and ECC blocks
  localparam reg_addr_t EccOffsetStart = 12'h080;

  // Configuration register offsets
  localparam reg_addr_t CfgSpmOffset     = 12'h000;
  localparam reg_addr_t CfgFlushOffset   = 12'h004;
  localparam reg_addr_t CfgFlushedOffset = 12'h008;

  // ECC manager offsets
  localparam reg_addr_t EccIntervalOffset = 12'h080;
  // One word per bank at base plus 4 times bank index
  localparam reg_addr_t EccFaultBase  = 12'h100;
  localparam reg_addr_t EccFixBase    = 12'h200;
  localparam reg_addr_t EccUncorrBase = 12'h300;

  // Access sequencer states
  typedef enum logic {
    IDLE,
    RESPOND
  } access_state_e;

  // Default cache geometry
  localparam int unsigned DefaultNumWays = 4;
  // Tag and data banks per way
  localparam int unsigned DefaultEccPerWay = 2;

endpackage

// ==== llc_reg_ctrl.sv ====
`timescale 1ns/10ps

module llc_reg_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  llc_reg_pkg::reg_req_t reg_req_i,
  output llc_reg_pkg::reg_rsp_t reg_rsp_o,
  output llc_reg_pkg::reg_addr_t acc_addr_o,
  output llc_reg_pkg::reg_data_t acc_wdata_o,
  output logic                  cfg_we_o,
  output logic                  ecc_we_o,
  input  llc_reg_pkg::reg_data_t cfg_rdata_i,
  input  llc_reg_pkg::reg_data_t ecc_rdata_i,
  input  logic                  cfg_hit_i,
  input  logic                  ecc_hit_i
);

  import llc_reg_pkg::*;

  access_state_e state_q;

  // Latched request
  logic      write_q;
  reg_addr_t addr_q;
  reg_data_t wdata_q;

  // Registered response
  logic      ready_q;
  logic      error_q;
  reg_data_t rdata_q;

  // Region select and the selected block's answer
  logic      sel_ecc;
  logic      sel_hit;
  reg_data_t sel_rdata;
  logic      accept;

  // New request only when idle and not in the ready cycle of the last one
  assign accept = (state_q == IDLE) && reg_req_i.valid && !ready_q;

  // Region decode, ECC block owns everything from its start offset up
  assign sel_ecc   = (addr_q >= EccOffsetStart);
  assign sel_hit   = sel_ecc ? ecc_hit_i : cfg_hit_i;
  assign sel_rdata = sel_ecc ? ecc_rdata_i : cfg_rdata_i;

  // Write strobes land on the same edge that registers ready
  assign cfg_we_o = (state_q == RESPOND) && write_q && !sel_ecc && cfg_hit_i;
  assign ecc_we_o = (state_q == RESPOND) && write_q && sel_ecc && ecc_hit_i;

  // Blocks decode their offsets from the latched request
  assign acc_addr_o  = addr_q;
  assign acc_wdata_o = wdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= RESPOND;
          end
        end
        RESPOND: begin
          ready_q <= 1'b1;
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request payload capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= reg_req_i.write;
      addr_q  <= reg_req_i.addr;
      wdata_q <= reg_req_i.wdata;
    end
  end

  // Response payload, unmapped offsets read as zero with error
  always_ff @(posedge clk_i) begin
    if (state_q == RESPOND) begin
      error_q <= !sel_hit;
      rdata_q <= sel_hit ? sel_rdata : '0;
    end
  end

  assign reg_rsp_o.ready = ready_q;
  assign reg_rsp_o.error = error_q;
  assign reg_rsp_o.rdata = rdata_q;

endmodule

// ==== llc_cfg_regs.sv ====
`timescale 1ns/10ps

module llc_cfg_regs #(
  parameter int unsigned NumWays = llc_reg_pkg::DefaultNumWays
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  llc_reg_pkg::reg_addr_t addr_i,
  input  llc_reg_pkg::reg_data_t wdata_i,
  input  logic                   we_i,
  output llc_reg_pkg::reg_data_t rdata_o,
  output logic                   hit_o,
  input  logic [NumWays-1:0]     flushed_i,
  output logic [NumWays-1:0]     flush_o,
  output logic [NumWays-1:0]     spm_ways_o
);

  import llc_reg_pkg::*;

  // One bit per cache way
  typedef logic [NumWays-1:0] way_vec_t;

  way_vec_t spm_q;
  way_vec_t pend_q;
  way_vec_t flush_set;
  logic     spm_we;

  // Offset decode for writes
  assign spm_we    = we_i && (addr_i == CfgSpmOffset);
  assign flush_set = (we_i && (addr_i == CfgFlushOffset)) ? wdata_i[NumWays-1:0] : '0;

  // Scratch-pad way mask, bits above NumWays are dropped
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      spm_q <= '0;
    end else if (spm_we) begin
      spm_q <= wdata_i[NumWays-1:0];
    end
  end

  // Pending flush bits
  // A bit drops one cycle after the core reports that way flushed
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~flushed_i) | flush_set;
    end
  end

  // Read mux and hit flag
  // FLUSHED is read-only, writes there hit but change nothing
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b0;
    case (addr_i)
      CfgSpmOffset: begin
        hit_o   = 1'b1;
        rdata_o = reg_data_t'(spm_q);
      end
      CfgFlushOffset: begin
        hit_o   = 1'b1;
        rdata_o = reg_data_t'(pend_q);
      end
      CfgFlushedOffset: begin
        hit_o   = 1'b1;
        rdata_o = reg_data_t'(flushed_i);
      end
      default: begin
        hit_o   = 1'b0;
        rdata_o = '0;
      end
    endcase
  end

  // Level outputs toward the cache core
  assign flush_o    = pend_q;
  assign spm_ways_o = spm_q;

endmodule

// ==== llc_ecc_mgr.sv ====
`timescale 1ns/10ps

module llc_ecc_mgr #(
  parameter int unsigned NumWays   = llc_reg_pkg::DefaultNumWays,
  parameter int unsigned EccPerWay = llc_reg_pkg::DefaultEccPerWay
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  llc_reg_pkg::reg_addr_t         addr_i,
  input  llc_reg_pkg::reg_data_t         wdata_i,
  input  logic                           we_i,
  output llc_reg_pkg::reg_data_t         rdata_o,
  output logic                           hit_o,
  input  logic [NumWays*EccPerWay-1:0]   bank_fault_i,
  input  logic [NumWays*EccPerWay-1:0]   scrub_fix_i,
  input  logic [NumWays*EccPerWay-1:0]   scrub_uncorr_i,
  output logic [NumWays*EccPerWay-1:0]   scrub_trigger_o
);

  import llc_reg_pkg::*;

  localparam int unsigned NumBanks = NumWays * EccPerWay;
  // Counter arrays: fault, scrub fix, uncorrectable
  localparam int unsigned NumKinds = 3;
  localparam int unsigned PtrW     = (NumBanks > 1) ? $clog2(NumBanks) : 1;

  typedef logic [NumBanks-1:0] bank_vec_t;
  typedef logic [PtrW-1:0]     bank_idx_t;
  // Word index inside a counter array
  typedef logic [5:0]          word_idx_t;

  // Upper nibble selects the counter array
  localparam reg_addr_t RegionMask = 12'hF00;
  localparam reg_addr_t [NumKinds-1:0] KindBase = {EccUncorrBase, EccFixBase, EccFaultBase};

  reg_data_t cnt_q [NumKinds][NumBanks];
  logic [NumKinds-1:0][NumBanks-1:0] evt;
  logic [NumKinds-1:0][NumBanks-1:0] acc_match;
  word_idx_t word_idx;

  // Scrub trigger state
  reg_data_t interval_q;
  reg_data_t tick_q;
  bank_idx_t ptr_q;
  bank_vec_t trig_q;

  assign evt      = {scrub_uncorr_i, scrub_fix_i, bank_fault_i};
  assign word_idx = addr_i[7:2];

  // Which counter word the current access points at
  always_comb begin
    acc_match = '0;
    for (int k = 0; k < NumKinds; k++) begin
      for (int b = 0; b < NumBanks; b++) begin
        acc_match[k][b] = ((addr_i & RegionMask) == KindBase[k]) &&
                          (addr_i[1:0] == 2'b00) && (word_idx == word_idx_t'(b));
      end
    end
  end

  // Saturating event counters, a write of any value clears
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NumKinds; k++) begin
      for (int b = 0; b < NumBanks; b++) begin
        if (rst_i) begin
          cnt_q[k][b] <= '0;
        end else if (we_i && acc_match[k][b]) begin
          cnt_q[k][b] <= '0;
        end else if (evt[k][b] && (cnt_q[k][b] != '1)) begin
          cnt_q[k][b] <= cnt_q[k][b] + 1'b1;
        end
      end
    end
  end

  // Read mux, only the interval and in-range counters hit
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b0;
    if (addr_i == EccIntervalOffset) begin
      hit_o   = 1'b1;
      rdata_o = interval_q;
    end
    for (int k = 0; k < NumKinds; k++) begin
      for (int b = 0; b < NumBanks; b++) begin
        if (acc_match[k][b]) begin
          hit_o   = 1'b1;
          rdata_o = cnt_q[k][b];
        end
      end
    end
  end

  // Scrub interval register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      interval_q <= '0;
    end else if (we_i && (addr_i == EccIntervalOffset)) begin
      interval_q <= wdata_i;
    end
  end

  // Down-counter fires on zero and reloads interval minus one
  // Zero interval parks the pointer on bank 0
  always_ff @(posedge clk_i) begin
    if (rst_i || (interval_q == '0)) begin
      tick_q <= '0;
      ptr_q  <= '0;
      trig_q <= '0;
    end else if (tick_q == '0) begin
      tick_q <= interval_q - 1'b1;
      trig_q <= bank_vec_t'(1) << ptr_q;
      ptr_q  <= (ptr_q == bank_idx_t'(NumBanks - 1)) ? '0 : ptr_q + 1'b1;
    end else begin
      tick_q <= tick_q - 1'b1;
      trig_q <= '0;
    end
  end

  assign scrub_trigger_o = trig_q;

endmodule

// ==== llc_reg_wrap.sv ====
`timescale 1ns/10ps

module llc_reg_wrap #(
  parameter int unsigned NumWays   = llc_reg_pkg::DefaultNumWays,
  parameter int unsigned EccPerWay = llc_reg_pkg::DefaultEccPerWay
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  llc_reg_pkg::reg_req_t        reg_req_i,
  output llc_reg_pkg::reg_rsp_t        reg_rsp_o,
  input  logic [NumWays-1:0]           flushed_i,
  output logic [NumWays-1:0]           flush_o,
  output logic [NumWays-1:0]           spm_ways_o,
  input  logic [NumWays*EccPerWay-1:0] bank_fault_i,
  input  logic [NumWays*EccPerWay-1:0] scrub_fix_i,
  input  logic [NumWays*EccPerWay-1:0] scrub_uncorr_i,
  output logic [NumWays*EccPerWay-1:0] scrub_trigger_o
);

  import llc_reg_pkg::*;

  // Latched access shared by both blocks
  reg_addr_t acc_addr;
  reg_data_t acc_wdata;
  // Per-block strobes and answers
  logic      cfg_we;
  logic      ecc_we;
  reg_data_t cfg_rdata;
  reg_data_t ecc_rdata;
  logic      cfg_hit;
  logic      ecc_hit;

  // Access sequencer and region decode
  llc_reg_ctrl llc_reg_ctrl_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_req_i   (reg_req_i),
    .reg_rsp_o   (reg_rsp_o),
    .acc_addr_o  (acc_addr),
    .acc_wdata_o (acc_wdata),
    .cfg_we_o    (cfg_we),
    .ecc_we_o    (ecc_we),
    .cfg_rdata_i (cfg_rdata),
    .ecc_rdata_i (ecc_rdata),
    .cfg_hit_i   (cfg_hit),
    .ecc_hit_i   (ecc_hit)
  );

  // Scratch-pad and flush control
  llc_cfg_regs #(
    .NumWays (NumWays)
  ) llc_cfg_regs_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .addr_i     (acc_addr),
    .wdata_i    (acc_wdata),
    .we_i       (cfg_we),
    .rdata_o    (cfg_rdata),
    .hit_o      (cfg_hit),
    .flushed_i  (flushed_i),
    .flush_o    (flush_o),
    .spm_ways_o (spm_ways_o)
  );

  // ECC counters and scrub trigger, one bank per tag or data array
  llc_ecc_mgr #(
    .NumWays   (NumWays),
    .EccPerWay (EccPerWay)
  ) llc_ecc_mgr_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .addr_i          (acc_addr),
    .wdata_i         (acc_wdata),
    .we_i            (ecc_we),
    .rdata_o         (ecc_rdata),
    .hit_o           (ecc_hit),
    .bank_fault_i    (bank_fault_i),
    .scrub_fix_i     (scrub_fix_i),
    .scrub_uncorr_i  (scrub_uncorr_i),
    .scrub_trigger_o (scrub_trigger_o)
  );

endmodule

// ==== llc_reg_wrap_sva.sv ====
`timescale 1ns/10ps

module llc_reg_wrap_sva #(
  parameter int unsigned NumBanks = 8
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input llc_reg_pkg::reg_req_t reg_req_i,
  input llc_reg_pkg::reg_rsp_t reg_rsp_i,
  input logic                  cfg_we_i,
  input logic                  ecc_we_i,
  input logic [NumBanks-1:0]   scrub_trigger_i
);

  // Ready is a single-cycle pulse
  ready_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
    reg_rsp_i.ready |=> !reg_rsp_i.ready)
    else $error("ready stayed high for more than one cycle");

  // Two edges from first sampled valid to ready
  ready_latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(reg_req_i.valid) |-> !reg_rsp_i.ready ##1 !reg_rsp_i.ready ##1 reg_rsp_i.ready)
    else $error("ready did not follow valid by exactly two cycles");

  // Strobe lands on the edge that registers the response
  no_strobe_on_error_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (cfg_we_i || ecc_we_i) |=> !reg_rsp_i.error)
    else $error("write strobe fired for an access answered with error");

  // Round-robin scrub, never two banks at once
  trigger_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(scrub_trigger_i))
    else $error("scrub_trigger_o has more than one bit set");

endmodule

bind llc_reg_wrap llc_reg_wrap_sva #(
  .NumBanks (NumWays * EccPerWay)
) llc_reg_wrap_sva_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .reg_req_i       (reg_req_i),
  .reg_rsp_i       (reg_rsp_o),
  .cfg_we_i        (cfg_we),
  .ecc_we_i        (ecc_we),
  .scrub_trigger_i (scrub_trigger_o)
);

// ==== tb_llc_reg_wrap.sv ====
`timescale 1ns/10ps

module tb_llc_reg_wrap;

  import llc_reg_pkg::*;

  localparam int unsigned NumWays   = 4;
  localparam int unsigned EccPerWay = 2;
  localparam int unsigned NumBanks  = NumWays * EccPerWay;
  // Cycles allowed for one bus access to answer
  localparam int unsigned BusTimeout = 20;

  logic                clk;
  logic                rst;
  reg_req_t            req;
  reg_rsp_t            rsp;
  logic [NumWays-1:0]  flushed;
  logic [NumWays-1:0]  flush;
  logic [NumWays-1:0]  spm_ways;
  logic [NumBanks-1:0] bank_fault;
  logic [NumBanks-1:0] scrub_fix;
  logic [NumBanks-1:0] scrub_uncorr;
  logic [NumBanks-1:0] scrub_trigger;

  int   errors;
  int   checks;
  int   seed;
  logic timed_out;

  llc_reg_wrap #(
    .NumWays   (NumWays),
    .EccPerWay (EccPerWay)
  ) llc_reg_wrap_i (
    .clk_i           (clk),
    .rst_i           (rst),
    .reg_req_i       (req),
    .reg_rsp_o       (rsp),
    .flushed_i       (flushed),
    .flush_o         (flush),
    .spm_ways_o      (spm_ways),
    .bank_fault_i    (bank_fault),
    .scrub_fix_i     (scrub_fix),
    .scrub_uncorr_i  (scrub_uncorr),
    .scrub_trigger_o (scrub_trigger)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // One register access, valid held until ready, random idle gap first
  task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                            output reg_data_t rdata, output logic error);
    int gap;
    int waited;
    gap   = {$random(seed)} % 4;
    rdata = '0;
    error = 1'b0;
    // At least one idle cycle after the previous ready
    repeat (gap + 1) begin
      @(posedge clk);
      #1;
    end
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    waited = 0;
    while (!rsp.ready && waited < BusTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (rsp.ready) begin
      rdata = rsp.rdata;
      error = rsp.error;
    end else begin
      errors++;
      timed_out = 1'b1;
      $display("Bus access to address 0x%h never got ready", addr);
    end
    req.valid = 1'b0;
  endtask

  // Single-cycle event pulses on one bank, a quiet cycle after each
  task automatic pulse_events(input string kind, input int bank, input int count);
    logic [NumBanks-1:0] one;
    one = NumBanks'(1) << bank;
    repeat (count) begin
      if (kind == "FAULT") bank_fault = one;
      else if (kind == "FIX") scrub_fix = one;
      else scrub_uncorr = one;
      @(posedge clk);
      #1;
      bank_fault   = '0;
      scrub_fix    = '0;
      scrub_uncorr = '0;
      @(posedge clk);
      #1;
    end
  endtask

  // Records trigger pulses, bank index advances by one and wraps
  // A count of zero means no pulse may show in the window
  task automatic watch_triggers(input int count, input int first, input int window);
    int waited;
    if (count == 0) begin
      repeat (window) begin
        @(posedge clk);
        #1;
        compare_value("scrub_trigger_o", 32'(scrub_trigger), 32'h0);
      end
      return;
    end
    for (int i = 0; i < count; i++) begin
      waited = 0;
      do begin
        @(posedge clk);
        #1;
        waited++;
      end while (scrub_trigger == '0 && waited < window);
      if (scrub_trigger == '0) begin
        errors++;
        timed_out = 1'b1;
        $display("Scrub trigger pulse %0d did not arrive within %0d cycles", i, window);
        return;
      end
      compare_value("scrub_trigger_o", 32'(scrub_trigger),
                    32'(NumBanks'(1) << ((first + i) % NumBanks)));
    end
  endtask

  initial begin
    string     op;
    string     rest;
    int        fd;
    int        n;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    reg_data_t rdata;
    logic      error;
    errors       = 0;
    checks       = 0;
    timed_out    = 1'b0;
    seed         = 32'ha3e3_ea69;
    rst          = 1'b1;
    req          = '0;
    flushed      = '0;
    bank_fault   = '0;
    scrub_fix    = '0;
    scrub_uncorr = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // Outputs idle out of reset
    compare_value("reg_rsp_o.ready", 32'(rsp.ready), 32'h0);
    compare_value("flush_o", 32'(flush), 32'h0);
    compare_value("spm_ways_o", 32'(spm_ways), 32'h0);
    compare_value("scrub_trigger_o", 32'(scrub_trigger), 32'h0);
    fd = $fopen("llc_reg_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file llc_reg_trace.txt");
    end
    while (fd != 0 && !timed_out) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) break;
      if (op == "#") begin
        n = $fgets(rest, fd);
      end else if (op == "WR") begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        bus_access(1'b1, a[11:0], b, rdata, error);
        compare_value($sformatf("reg_rsp_o.error at 0x%h", a[11:0]), 32'(error), c);
      end else if (op == "RD") begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        bus_access(1'b0, a[11:0], '0, rdata, error);
        compare_value($sformatf("reg_rsp_o.rdata at 0x%h", a[11:0]), rdata, b);
        compare_value($sformatf("reg_rsp_o.error at 0x%h", a[11:0]), 32'(error), c);
        // Level outputs mirror the SPM and FLUSH registers
        if (a[11:0] == CfgSpmOffset) begin
          compare_value("spm_ways_o", 32'(spm_ways), 32'(b[NumWays-1:0]));
        end
        if (a[11:0] == CfgFlushOffset) begin
          compare_value("flush_o", 32'(flush), 32'(b[NumWays-1:0]));
        end
      end else if (op == "FAULT" || op == "FIX" || op == "UNCORR") begin
        n = $fscanf(fd, "%h %h", a, b);
        pulse_events(op, int'(a), int'(b));
      end else if (op == "FLUSHED") begin
        n = $fscanf(fd, "%h", a);
        flushed[a[1:0]] = 1'b1;
        @(posedge clk);
        #1;
        flushed = '0;
      end else if (op == "WAIT") begin
        n = $fscanf(fd, "%h", a);
        repeat (int'(a)) begin
          @(posedge clk);
          #1;
        end
      end else if (op == "TRIG") begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        watch_triggers(int'(a), int'(b), int'(c));
      end else begin
        errors++;
        $display("Unknown trace opcode %s", op);
        n = $fgets(rest, fd);
      end
    end
    if (fd != 0) $fclose(fd);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== llc_reg_trace.txt ====
# WR addr data experr / RD addr expdata experr / FAULT FIX UNCORR bank count
# FLUSHED way / WAIT cycles / TRIG pulses firstbank window (0 pulses means none allowed)
RD 000 00000000 0
RD 004 00000000 0
RD 100 00000000 0
WR 000 FFFFFFF5 0
RD 000 00000005 0
RD 040 00000000 1
RD 400 00000000 1
WR 040 0000000F 1
WR 400 00000007 1
RD 000 00000005 0
RD 008 00000000 0
WR 004 00000006 0
RD 004 00000006 0
FLUSHED 1
RD 004 00000004 0
FAULT 3 2
FIX 5 4
UNCORR 7 1
FAULT 0 1
WAIT 2
RD 10C 00000002 0
RD 100 00000001 0
RD 214 00000004 0
RD 31C 00000001 0
RD 104 00000000 0
WR 10C 00000123 0
RD 10C 00000000 0
RD 120 00000000 1
WR 080 00000005 0
TRIG A 0 14
RD 080 00000005 0
WR 080 00000000 0
TRIG 0 0 32

// ==== tb.f ====
llc_reg_pkg.sv
llc_reg_ctrl.sv
llc_cfg_regs.sv
llc_ecc_mgr.sv
llc_reg_wrap.sv
llc_reg_wrap_sva.sv
tb_llc_reg_wrap.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_llc_reg_wrap -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" "$LOG"; then
  exit 0
fi
exit 1
